/* include/loader_defs.svh */
/*
 * Constants for the host download loader: bus widths, host index codes
 * and the fixed target addresses. Include wherever one of them is used.
 */

`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// ========================================
// Widths
// ========================================
`define LD_ADDR_W           23
`define LD_PRG_ADDR_W       16
`define LD_BEAT_ADDR_W      25

// ========================================
// Host download index codes
// ========================================
`define LD_IDX_ROM          8'h00
`define LD_IDX_PRG          8'h01
`define LD_IDX_PRG_ALT      8'h41
`define LD_IDX_TAP          8'h81

// ========================================
// Fixed addresses
// ========================================
// Tape images live above the machine address space
`define LD_TAP_MEM_START    23'h20000
`define LD_CART_BASE        16'hA000
`define LD_CART_LAST        16'hBFFF
`define LD_TAP_VERSION_OFS  25'h0000C

`endif

/* logic/loader_pkg.sv */
/*
 * Types shared by the loader units: download kinds, injection steps,
 * the host beat and the memory write record.
 */

`include "loader_defs.svh"

package loader_pkg;

    // Kind of the running host download
    typedef enum logic [1:0] {
        DL_NONE,
        DL_ROM,
        DL_PRG,
        DL_TAP
    } dl_kind_e;

    // Phase of the BASIC pointer injection
    typedef enum logic [1:0] {
        INJ_IDLE,
        INJ_WRITE,
        INJ_GAP,
        INJ_RESET
    } inject_step_e;

    // One byte from the host, wr is a single-cycle strobe
    typedef struct packed {
        logic                       wr;
        logic [`LD_BEAT_ADDR_W-1:0] addr;
        logic [7:0]                 data;
    } dl_beat_t;

    // Memory write towards the emulated machine
    typedef struct packed {
        logic                  valid;
        logic [`LD_ADDR_W-1:0] addr;
        logic [7:0]            data;
        logic                  internal;
    } mem_wr_t;

endpackage

/* logic/download_ctrl.sv */
/*
 * Download sequencing. Decodes the host index into a download kind, flags
 * the end of a PRG load and steps through pointer injection and auto-reset.
 */

`include "loader_defs.svh"

module download_ctrl (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     download_i,
    input  logic [7:0]               index_i,
    output loader_pkg::dl_kind_e     kind_o,
    output logic                     prg_end_o,
    output loader_pkg::inject_step_e inj_step_o,
    output logic [2:0]               inj_index_o,
    input  logic                     auto_reset_arm_i,
    output logic                     force_reset_o
);
    import loader_pkg::*;

    // Counter runs 1..31, then wraps back to idle
    localparam logic [4:0] INJ_START = 5'd1;
    localparam logic [4:0] INJ_LAST  = 5'd31;

    dl_kind_e   kind_q;
    logic [4:0] inj_cnt_q;
    logic       reset_pending_q;

    // ========================================
    // Kind decode
    // ========================================
    always_comb begin
        kind_o = DL_NONE;
        if (download_i) begin
            case (index_i)
                `LD_IDX_ROM:                 kind_o = DL_ROM;
                `LD_IDX_PRG, `LD_IDX_PRG_ALT: kind_o = DL_PRG;
                `LD_IDX_TAP:                 kind_o = DL_TAP;
                default:                     kind_o = DL_NONE;
            endcase
        end
    end

    // High in the first cycle after a PRG load has finished
    assign prg_end_o = (kind_q == DL_PRG) && (kind_o != DL_PRG);

    // ========================================
    // Injection sequence
    // ========================================
    // Odd counts in the lower half write a pointer, the rest are gaps
    always_comb begin
        if (inj_cnt_q == '0) begin
            inj_step_o = INJ_IDLE;
        end else if (inj_cnt_q == INJ_LAST) begin
            inj_step_o = INJ_RESET;
        end else if (!inj_cnt_q[4] && inj_cnt_q[0]) begin
            inj_step_o = INJ_WRITE;
        end else begin
            inj_step_o = INJ_GAP;
        end
    end

    assign inj_index_o = inj_cnt_q[3:1];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            kind_q          <= DL_NONE;
            inj_cnt_q       <= '0;
            reset_pending_q <= 1'b0;
            force_reset_o   <= 1'b0;
        end else begin
            kind_q        <= kind_o;
            force_reset_o <= 1'b0;

            if (prg_end_o) begin
                inj_cnt_q <= INJ_START;
            end else if (inj_cnt_q != '0) begin
                inj_cnt_q <= inj_cnt_q + 5'd1;
            end

            // Arm is sampled as the load ends, the address unit clears it then
            if (prg_end_o) begin
                reset_pending_q <= auto_reset_arm_i;
            end else if (inj_step_o == INJ_RESET) begin
                reset_pending_q <= 1'b0;
                force_reset_o   <= reset_pending_q;
            end
        end
    end

endmodule

/* logic/load_addr_gen.sv */
/*
 * PRG and TAP address generation. Parses the PRG load header, advances the
 * load address per byte, tracks the tape image end and its version bit.
 */

`include "loader_defs.svh"

module load_addr_gen (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  loader_pkg::dl_kind_e         kind_i,
    input  loader_pkg::dl_beat_t         beat_i,
    input  logic                         no_header_i,
    input  logic                         prg_end_i,
    output logic [`LD_PRG_ADDR_W-1:0]    prg_addr_o,
    output logic                         auto_reset_arm_o,
    output logic                         tap_version_o,
    output logic [`LD_ADDR_W-1:0]        tap_last_addr_o,
    output loader_pkg::mem_wr_t          wr_o
);
    import loader_pkg::*;

    // Header byte offsets and the first data byte
    localparam logic [`LD_BEAT_ADDR_W-1:0] OFS_HDR_LO = 0;
    localparam logic [`LD_BEAT_ADDR_W-1:0] OFS_HDR_HI = 1;
    localparam logic [`LD_BEAT_ADDR_W-1:0] OFS_DATA   = 2;

    logic [`LD_PRG_ADDR_W-1:0] prg_addr_q;
    logic [`LD_PRG_ADDR_W-1:0] prg_next;
    logic                      prg_wr;
    logic                      prg_internal;
    logic [`LD_ADDR_W-1:0]     tap_addr_q;
    logic [`LD_ADDR_W-1:0]     tap_next;
    logic                      tap_wr;
    logic                      arm_q;
    logic                      tap_version_q;

    // ========================================
    // PRG address
    // ========================================
    always_comb begin
        prg_next = prg_addr_q;
        prg_wr   = 1'b0;
        if (kind_i == DL_PRG && beat_i.wr) begin
            if (!no_header_i) begin
                if (beat_i.addr == OFS_HDR_LO) begin
                    prg_next = {prg_addr_q[`LD_PRG_ADDR_W-1:8], beat_i.data};
                end else if (beat_i.addr == OFS_HDR_HI) begin
                    prg_next = {beat_i.data, prg_addr_q[7:0]};
                end else begin
                    prg_wr = 1'b1;
                    // First data byte lands on the header address itself
                    if (beat_i.addr != OFS_DATA && prg_addr_q != `LD_CART_LAST) begin
                        prg_next = prg_addr_q + 1'b1;
                    end
                end
            end else begin
                prg_wr = 1'b1;
                if (beat_i.addr == OFS_HDR_LO) begin
                    prg_next = `LD_CART_BASE;
                end else if (prg_addr_q != `LD_CART_LAST) begin
                    prg_next = prg_addr_q + 1'b1;
                end
            end
        end
    end

    // Low RAM, 4K block at 1000 and colour RAM
    assign prg_internal = (prg_next[15:10] == 6'b000000) ||
                          (prg_next[15:12] == 4'b0001)   ||
                          (prg_next[15:10] == 6'b100101);

    // ========================================
    // TAP address
    // ========================================
    assign tap_wr   = (kind_i == DL_TAP) && beat_i.wr;
    assign tap_next = !tap_wr ? tap_addr_q :
                      (beat_i.addr == '0) ? `LD_TAP_MEM_START : tap_addr_q + 1'b1;

    always_comb begin
        wr_o = '0;
        if (prg_wr) begin
            wr_o.valid    = 1'b1;
            wr_o.addr     = `LD_ADDR_W'(prg_next);
            wr_o.data     = beat_i.data;
            wr_o.internal = prg_internal;
        end else if (tap_wr) begin
            wr_o.valid    = 1'b1;
            wr_o.addr     = tap_next;
            wr_o.data     = beat_i.data;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prg_addr_q    <= '0;
            tap_addr_q    <= `LD_TAP_MEM_START;
            arm_q         <= 1'b0;
            tap_version_q <= 1'b0;
        end else begin
            prg_addr_q <= prg_next;
            tap_addr_q <= tap_next;

            // A write at the cartridge base means a cartridge image
            if (prg_end_i) begin
                arm_q <= 1'b0;
            end else if (prg_wr && prg_next == `LD_CART_BASE) begin
                arm_q <= 1'b1;
            end

            if (tap_wr && beat_i.addr == `LD_TAP_VERSION_OFS) begin
                tap_version_q <= beat_i.data[0];
            end
        end
    end

    assign prg_addr_o       = prg_addr_q;
    assign auto_reset_arm_o = arm_q;
    assign tap_version_o    = tap_version_q;
    assign tap_last_addr_o  = tap_addr_q;

endmodule

/* logic/rom_addr_map.sv */
/*
 * ROM image placement. Maps 8K regions of the image onto the kernal, BASIC
 * and character ROM locations; the drive ROM region is not written here.
 */

`include "loader_defs.svh"

module rom_addr_map (
    input  loader_pkg::dl_kind_e kind_i,
    input  loader_pkg::dl_beat_t beat_i,
    output loader_pkg::mem_wr_t  wr_o
);
    import loader_pkg::*;

    localparam logic [`LD_ADDR_W-1:0] KERNAL_PAL_BASE  = 23'h0E000;
    localparam logic [`LD_ADDR_W-1:0] KERNAL_NTSC_BASE = 23'h1E000;
    localparam logic [`LD_ADDR_W-1:0] BASIC_BASE       = 23'h0C000;
    localparam logic [`LD_ADDR_W-1:0] CHAR_BASE        = 23'h08000;

    logic [`LD_ADDR_W-1:0] ofs_8k;
    logic [`LD_ADDR_W-1:0] ofs_4k;

    assign ofs_8k = `LD_ADDR_W'(beat_i.addr[12:0]);
    // Character ROM is only 4K
    assign ofs_4k = `LD_ADDR_W'(beat_i.addr[11:0]);

    always_comb begin
        wr_o      = '0;
        wr_o.data = beat_i.data;
        if (kind_i == DL_ROM && beat_i.wr) begin
            case (beat_i.addr[15:13])
                3'b010: begin
                    wr_o.valid = 1'b1;
                    wr_o.addr  = KERNAL_PAL_BASE + ofs_8k;
                end
                3'b011: begin
                    wr_o.valid = 1'b1;
                    wr_o.addr  = KERNAL_NTSC_BASE + ofs_8k;
                end
                3'b100: begin
                    wr_o.valid = 1'b1;
                    wr_o.addr  = BASIC_BASE + ofs_8k;
                end
                3'b101: begin
                    wr_o.valid    = 1'b1;
                    wr_o.addr     = CHAR_BASE + ofs_4k;
                    wr_o.internal = 1'b1;
                end
                default: wr_o.valid = 1'b0;
            endcase
        end
    end

endmodule

/* logic/basic_ptr_inject.sv */
/*
 * BASIC pointer writes after a PRG load. Each write step stores one byte
 * of the final load address into the zero page pointer table.
 */

`include "loader_defs.svh"

module basic_ptr_inject (
    input  loader_pkg::inject_step_e    inj_step_i,
    input  logic [2:0]                  inj_index_i,
    input  logic [`LD_PRG_ADDR_W-1:0]   prg_addr_i,
    output loader_pkg::mem_wr_t         wr_o
);
    import loader_pkg::*;

    logic [7:0] ptr_addr;

    // Start of variables, arrays and end of arrays, then the load end pointer
    always_comb begin
        case (inj_index_i)
            3'd0:    ptr_addr = 8'h2D;
            3'd1:    ptr_addr = 8'h2E;
            3'd2:    ptr_addr = 8'h2F;
            3'd3:    ptr_addr = 8'h30;
            3'd4:    ptr_addr = 8'h31;
            3'd5:    ptr_addr = 8'h32;
            3'd6:    ptr_addr = 8'hAE;
            default: ptr_addr = 8'hAF;
        endcase
    end

    always_comb begin
        wr_o.valid = (inj_step_i == INJ_WRITE);
        wr_o.addr  = `LD_ADDR_W'(ptr_addr);
        // Low byte on even entries, high byte on odd ones
        wr_o.data  = inj_index_i[0] ? prg_addr_i[`LD_PRG_ADDR_W-1:8] : prg_addr_i[7:0];
        wr_o.internal = 1'b1;
    end

endmodule

/* logic/loader_top.sv */
/*
 * Host download loader top level. Turns host bytes into memory writes
 * for ROM images, PRG files and tape images, one registered write per cycle.
 */

`include "loader_defs.svh"

module loader_top (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     download_i,
    input  logic [7:0]               index_i,
    input  loader_pkg::dl_beat_t     beat_i,
    input  logic                     no_header_i,
    output loader_pkg::mem_wr_t      mem_wr_o,
    output logic                     force_reset_o,
    output logic                     tap_version_o,
    output logic [`LD_ADDR_W-1:0]    tap_last_addr_o
);
    import loader_pkg::*;

    dl_kind_e                  kind;
    logic                      prg_end;
    inject_step_e              inj_step;
    logic [2:0]                inj_index;
    logic                      auto_reset_arm;
    logic [`LD_PRG_ADDR_W-1:0] prg_addr;
    mem_wr_t                   gen_wr;
    mem_wr_t                   rom_wr;
    mem_wr_t                   inj_wr;
    mem_wr_t                   wr_sel;
    mem_wr_t                   wr_q;

    download_ctrl i_download_ctrl (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .download_i       (download_i),
        .index_i          (index_i),
        .kind_o           (kind),
        .prg_end_o        (prg_end),
        .inj_step_o       (inj_step),
        .inj_index_o      (inj_index),
        .auto_reset_arm_i (auto_reset_arm),
        .force_reset_o    (force_reset_o)
    );

    load_addr_gen i_load_addr_gen (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .kind_i           (kind),
        .beat_i           (beat_i),
        .no_header_i      (no_header_i),
        .prg_end_i        (prg_end),
        .prg_addr_o       (prg_addr),
        .auto_reset_arm_o (auto_reset_arm),
        .tap_version_o    (tap_version_o),
        .tap_last_addr_o  (tap_last_addr_o),
        .wr_o             (gen_wr)
    );

    rom_addr_map i_rom_addr_map (
        .kind_i (kind),
        .beat_i (beat_i),
        .wr_o   (rom_wr)
    );

    basic_ptr_inject i_basic_ptr_inject (
        .inj_step_i  (inj_step),
        .inj_index_i (inj_index),
        .prg_addr_i  (prg_addr),
        .wr_o        (inj_wr)
    );

    // Sources never overlap, injection only runs with no download active
    always_comb begin
        if (inj_step == INJ_WRITE) begin
            wr_sel = inj_wr;
        end else if (kind == DL_ROM) begin
            wr_sel = rom_wr;
        end else begin
            wr_sel = gen_wr;
        end
    end

    always_ff @(posedge clk_sys) begin
        wr_q <= wr_sel;
        if (reset) begin
            wr_q.valid <= 1'b0;
        end
    end

    assign mem_wr_o = wr_q;

endmodule

/* sim/loader_sva.sv */
/*
 * Assertions bound to the loader top level. They watch the output strobes
 * around reset and the host usage rule during pointer injection.
 */

module loader_sva (
    input logic                     clk_sys,
    input logic                     reset,
    input logic                     download_i,
    input logic                     mem_valid_i,
    input logic                     force_reset_i,
    input loader_pkg::inject_step_e inj_step_i
);
    import loader_pkg::*;

    // Quiet outputs and an idle injection right after reset
    a_quiet_after_reset : assert property (@(posedge clk_sys)
        reset |=> !mem_valid_i && !force_reset_i && inj_step_i == INJ_IDLE)
        else $error("write strobe, reset strobe or injection active after reset");

    a_reset_one_cycle : assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_i |=> !force_reset_i)
        else $error("force reset strobe longer than one cycle");

    // No back-pressure, so the host must wait for injection to finish
    a_no_download_in_inject : assert property (@(posedge clk_sys) disable iff (reset)
        $rose(download_i) |-> inj_step_i == INJ_IDLE)
        else $error("download started while pointer injection was running");

endmodule

bind loader_top loader_sva i_loader_sva (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .download_i    (download_i),
    .mem_valid_i   (mem_wr_o.valid),
    .force_reset_i (force_reset_o),
    .inj_step_i    (inj_step)
);

/* sim/tb_loader.sv */
/*
 * Testbench for the host download loader. Replays the download records of
 * the stimulus file and checks every memory write and the auto-reset pulse.
 */

`include "loader_defs.svh"

module tb_loader;
    import loader_pkg::*;

    localparam logic [31:0] SEED         = 32'h8df4_3138;
    localparam int          INJ_WAIT_MAX = 8;
    // Covers the 16-cycle gap after the last pointer and the reset pulse
    localparam int          RESET_WINDOW = 24;

    logic                  clk_sys = 1'b0;
    logic                  reset;
    logic                  download;
    logic [7:0]            index;
    dl_beat_t              beat;
    logic                  no_header;
    mem_wr_t               mem_wr;
    logic                  force_reset;
    logic                  tap_version;
    logic [`LD_ADDR_W-1:0] tap_last_addr;

    logic [`LD_ADDR_W-1:0] exp_addr_q[$];
    logic [7:0]            exp_data_q[$];
    logic                  exp_int_q[$];
    logic                  reset_expected;
    logic                  tap_version_exp;
    logic [`LD_ADDR_W-1:0] tap_last_exp;
    logic [31:0]           rand_state;
    int                    errors;

    always #4 clk_sys = ~clk_sys;

    loader_top i_dut (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .download_i      (download),
        .index_i         (index),
        .beat_i          (beat),
        .no_header_i     (no_header),
        .mem_wr_o        (mem_wr),
        .force_reset_o   (force_reset),
        .tap_version_o   (tap_version),
        .tap_last_addr_o (tap_last_addr)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bulk beats go to a TAP image or a headerless PRG
    function automatic logic [`LD_ADDR_W-1:0] fill_addr(input logic [`LD_BEAT_ADDR_W-1:0] ofs);
        if (index == `LD_IDX_TAP) begin
            return `LD_TAP_MEM_START + ofs[`LD_ADDR_W-1:0];
        end else if (ofs >= `LD_BEAT_ADDR_W'(`LD_CART_LAST - `LD_CART_BASE)) begin
            return `LD_ADDR_W'(`LD_CART_LAST);
        end else begin
            return `LD_ADDR_W'(`LD_CART_BASE) + ofs[`LD_ADDR_W-1:0];
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic check_fields(input int got, input int want);
        if (got != want) begin
            errors++;
            $display("Stimulus record has %0d fields where %0d were expected", got, want);
        end
    endtask

    task automatic check_write(input logic [`LD_ADDR_W-1:0] addr, input logic [7:0] data,
                               input logic internal);
        if (mem_wr.valid !== 1'b1) begin
            errors++;
            $display("** Error @%0t: no write, expected %h <= %h", $time, addr, data);
        end else if (mem_wr.addr !== addr || mem_wr.data !== data ||
                     mem_wr.internal !== internal) begin
            errors++;
            $display("** Error @%0t: write %h <= %h int %b, expected %h <= %h int %b",
                     $time, mem_wr.addr, mem_wr.data, mem_wr.internal, addr, data, internal);
        end
    endtask

    task automatic check_no_write();
        if (mem_wr.valid !== 1'b0) begin
            errors++;
            $display("** Error @%0t: unexpected write %h <= %h", $time, mem_wr.addr, mem_wr.data);
        end
    endtask

    task automatic start_download(input logic [7:0] idx, input logic nohdr);
        next_cycle();
        download  = 1'b1;
        index     = idx;
        no_header = nohdr;
    endtask

    // One strobe with the result sampled a cycle later
    task automatic send_beat(input logic [`LD_BEAT_ADDR_W-1:0] ofs, input logic [7:0] data);
        next_cycle();
        beat.wr   = 1'b1;
        beat.addr = ofs;
        beat.data = data;
        next_cycle();
        beat.wr = 1'b0;
        if (index == `LD_IDX_TAP) begin
            tap_last_exp = `LD_TAP_MEM_START + ofs[`LD_ADDR_W-1:0];
            if (ofs == `LD_TAP_VERSION_OFS) begin
                tap_version_exp = data[0];
            end
        end
    endtask

    task automatic play_beat(input logic [`LD_BEAT_ADDR_W-1:0] ofs, input logic [7:0] data);
        send_beat(ofs, data);
        if (exp_addr_q.size() > 0) begin
            check_write(exp_addr_q.pop_front(), exp_data_q.pop_front(), exp_int_q.pop_front());
        end else begin
            check_no_write();
        end
    endtask

    task automatic fill_beats(input logic [`LD_BEAT_ADDR_W-1:0] first, input int count);
        logic [`LD_BEAT_ADDR_W-1:0] ofs;
        logic [7:0]                 data;
        int                         n;
        for (n = 0; n < count; n++) begin
            ofs        = first + `LD_BEAT_ADDR_W'(n);
            rand_state = lcg_next(rand_state);
            data       = rand_state[23:16];
            send_beat(ofs, data);
            check_write(fill_addr(ofs), data, 1'b0);
        end
    endtask

    task automatic end_download();
        int waited;
        int pulses;
        int n;
        next_cycle();
        download = 1'b0;
        // Pointer writes still queued come from the injection
        while (exp_addr_q.size() > 0) begin
            waited = 0;
            next_cycle();
            while (mem_wr.valid !== 1'b1 && waited < INJ_WAIT_MAX) begin
                next_cycle();
                waited++;
            end
            if (mem_wr.valid !== 1'b1) begin
                errors++;
                $display("Timeout waiting for the injected write to %h", exp_addr_q[0]);
                exp_addr_q.delete();
                exp_data_q.delete();
                exp_int_q.delete();
            end else begin
                check_write(exp_addr_q.pop_front(), exp_data_q.pop_front(),
                            exp_int_q.pop_front());
            end
        end
        pulses = 0;
        for (n = 0; n < RESET_WINDOW; n++) begin
            next_cycle();
            if (force_reset === 1'b1) begin
                pulses++;
            end
            check_no_write();
        end
        if (pulses != (reset_expected ? 1 : 0)) begin
            errors++;
            $display("** Error @%0t: %0d force resets, expected %0d", $time, pulses,
                     reset_expected ? 1 : 0);
        end
        if (index == `LD_IDX_TAP) begin
            if (tap_version !== tap_version_exp || tap_last_addr !== tap_last_exp) begin
                errors++;
                $display("** Error @%0t: TAP version %b end %h, expected %b end %h", $time,
                         tap_version, tap_last_addr, tap_version_exp, tap_last_exp);
            end
        end
        reset_expected = 1'b0;
    endtask

    initial begin
        int               fd;
        int               code;
        logic [63:0]      tok;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [31:0]      x;
        logic [8*256-1:0] skip;
        reset           = 1'b1;
        download        = 1'b0;
        index           = '0;
        beat            = '0;
        no_header       = 1'b0;
        reset_expected  = 1'b0;
        tap_version_exp = 1'b0;
        tap_last_exp    = `LD_TAP_MEM_START;
        rand_state      = SEED;
        errors          = 0;
        repeat (8) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        fd = $fopen("sim/loader_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open sim/loader_stimulus.txt, no stimulus was run");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(skip, fd);
                end else if (tok == "D") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    check_fields(code, 2);
                    start_download(a[7:0], d[0]);
                end else if (tok == "B") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    check_fields(code, 2);
                    play_beat(a[`LD_BEAT_ADDR_W-1:0], d[7:0]);
                end else if (tok == "F") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    check_fields(code, 2);
                    fill_beats(a[`LD_BEAT_ADDR_W-1:0], d);
                end else if (tok == "W") begin
                    code = $fscanf(fd, "%h %h %h", a, d, x);
                    check_fields(code, 3);
                    exp_addr_q.push_back(a[`LD_ADDR_W-1:0]);
                    exp_data_q.push_back(d[7:0]);
                    exp_int_q.push_back(x[0]);
                end else if (tok == "R") begin
                    reset_expected = 1'b1;
                end else if (tok == "E") begin
                    end_download();
                end else begin
                    errors++;
                    $display("Unknown record in the stimulus file, skipping it");
                end
            end
            $fclose(fd);
        end

        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("%0d expected writes were never seen", exp_addr_q.size());
        end
        $display("Loader checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim/loader_stimulus.txt */
# Hex columns. D index nohdr | B offset data | F first count | E end download | R reset after E
# W addr data internal queues a write for the next B, or for the injection after E
D 00 0
W 00E000 11 0
B 4000 11
W 00E123 22 0
B 4123 22
W 01E010 33 0
B 6010 33
W 00C005 44 0
B 8005 44
W 008001 55 1
B A001 55
B C000 66
B 0000 77
E
D 01 0
B 0 FE
B 1 03
W 0003FE 0B 1
B 2 0B
W 0003FF 08 1
B 3 08
W 000400 0A 0
B 4 0A
W 00002D 00 1
W 00002E 04 1
W 00002F 00 1
W 000030 04 1
W 000031 00 1
W 000032 04 1
W 0000AE 00 1
W 0000AF 04 1
E
D 01 1
W 00A000 C3 0
B 0 C3
F 1 2000
W 00BFFF 5A 0
B 2001 5A
W 00002D FF 1
W 00002E BF 1
W 00002F FF 1
W 000030 BF 1
W 000031 FF 1
W 000032 BF 1
W 0000AE FF 1
W 0000AF BF 1
R
E
D 41 0
B 0 01
B 1 12
W 001201 A9 1
B 2 A9
W 001202 00 1
B 3 00
W 00002D 02 1
W 00002E 12 1
W 00002F 02 1
W 000030 12 1
W 000031 02 1
W 000032 12 1
W 0000AE 02 1
W 0000AF 12 1
E
D 81 0
F 0 D
W 02000D 7E 0
B D 7E
E

/* verilog.f */
+incdir+include
logic/loader_pkg.sv
logic/download_ctrl.sv
logic/load_addr_gen.sv
logic/rom_addr_map.sv
logic/basic_ptr_inject.sv
logic/loader_top.sv
sim/loader_sva.sv
sim/tb_loader.sv

/* Bender.yml */
package:
  name: loader

sources:
  - include_dirs:
      - include
    files:
      - logic/loader_pkg.sv
      - logic/download_ctrl.sv
      - logic/load_addr_gen.sv
      - logic/rom_addr_map.sv
      - logic/basic_ptr_inject.sv
      - logic/loader_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/loader_sva.sv
      - sim/tb_loader.sv
